// File: common/lsu_iq_macros.svh
`ifndef LSU_IQ_MACROS_SVH
`define LSU_IQ_MACROS_SVH

// queue geometry
`define LSU_IQ_DEPTH 8
`define LSU_IQ_IDX_W 4 // tail count runs 0..8

// micro-op field widths
`define PRF_W 6
`define OPC_W 4

// scoreboard read ports per operand side for eight slots and two dispatch lanes
`define SB_PORTS 10

`endif

// File: common/lsu_iq_pkg.sv
`include "lsu_iq_macros.svh"

package lsu_iq_pkg;

    typedef logic [`PRF_W-1:0] prf_num_t;
    typedef logic [`OPC_W-1:0] opc_t;
    typedef logic [$clog2(`LSU_IQ_DEPTH)-1:0] slot_idx_t;
    typedef logic [15:0] imm_t;

    // decoded memory micro-op as seen by the execution unit
    typedef struct packed {
        logic     valid;
        opc_t     opcode;
        prf_num_t src0; // address base
        prf_num_t src1; // store data
        prf_num_t dst;
        imm_t     imm;
    } lsu_uop_t;

    // operand wake-up flags
    typedef struct packed {
        logic rdy0;
        logic rdy1;
    } opnd_rdy_t;

    // one queue slot
    typedef struct packed {
        lsu_uop_t  uop;
        opnd_rdy_t rdy;
        logic      is_store;
    } iq_entry_t;

    // per-slot control built by the queue
    typedef struct packed {
        logic enq_en;   // load from a dispatch lane
        logic enq_sel;  // 0 lane 0, 1 lane 1
        logic shift_en; // take the slot above
    } slot_ctrl_t;

endpackage

// File: issue_queue/iq_entry.sv
module iq_entry
    import lsu_iq_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  slot_ctrl_t ctrl,
    input  iq_entry_t  din_0,
    input  iq_entry_t  din_1,
    input  iq_entry_t  up_entry,
    input  opnd_rdy_t  up_rdy,
    input  logic       busy_0,
    input  logic       busy_1,
    output iq_entry_t  entry,
    output opnd_rdy_t  rdy_next,
    output prf_num_t   src_0,
    output prf_num_t   src_1
);

    iq_entry_t enq_data;
    iq_entry_t entry_next;

    // flags this slot will hold next cycle if it stays put
    assign rdy_next.rdy0 = ~busy_0;
    assign rdy_next.rdy1 = ~busy_1;

    assign src_0 = entry.uop.src0;
    assign src_1 = entry.uop.src1;

    assign enq_data = ctrl.enq_sel ? din_1 : din_0;

    always_comb begin
        if (ctrl.enq_en) begin
            entry_next = enq_data; // flags already merged with scoreboard
        end else if (ctrl.shift_en) begin
            entry_next = up_entry;
            entry_next.rdy = up_rdy; // upper slot's fresh flags
        end else begin
            entry_next = entry;
            entry_next.rdy = rdy_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            entry <= '0;
        end else begin
            entry <= entry_next;
        end
    end

endmodule

// File: issue_queue/iq_lsu.sv
`include "lsu_iq_macros.svh"

module iq_lsu
    import lsu_iq_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     enq_req_0,
    input  logic                     enq_req_1,
    input  iq_entry_t                din_0,
    input  iq_entry_t                din_1,
    input  logic                     deq_en,
    input  slot_idx_t                deq_idx,
    output iq_entry_t                deq_entry,
    output logic [`LSU_IQ_DEPTH-1:0] valid_vec,
    output logic [`LSU_IQ_DEPTH-1:0] ready_vec,
    output logic [`LSU_IQ_DEPTH-1:0] store_vec,
    output logic                     accepting,
    output prf_num_t [`SB_PORTS-1:0] sb_rd_num_0,
    output prf_num_t [`SB_PORTS-1:0] sb_rd_num_1,
    input  logic [`SB_PORTS-1:0]     busy_0,
    input  logic [`SB_PORTS-1:0]     busy_1
);

    logic [`LSU_IQ_IDX_W-1:0] tail;
    logic [`LSU_IQ_IDX_W-1:0] tail_deq;  // tail after this cycle's dequeue
    logic [`LSU_IQ_IDX_W-1:0] pos_0;
    logic [`LSU_IQ_IDX_W-1:0] pos_1;
    logic                     acc_0;
    logic                     acc_1;
    iq_entry_t                din_0_m;
    iq_entry_t                din_1_m;
    iq_entry_t                entries [`LSU_IQ_DEPTH:0];
    opnd_rdy_t                rdy_nxt [`LSU_IQ_DEPTH:0];
    slot_ctrl_t               ctrl [`LSU_IQ_DEPTH-1:0];

    // room for two more entries
    assign accepting = (tail <= `LSU_IQ_IDX_W'(`LSU_IQ_DEPTH - 2));

    assign acc_0 = enq_req_0 & accepting;
    assign acc_1 = enq_req_1 & accepting;

    assign tail_deq = tail - `LSU_IQ_IDX_W'(deq_en);
    assign pos_0    = tail_deq;
    assign pos_1    = tail_deq + `LSU_IQ_IDX_W'(acc_0); // lane 1 packs down if lane 0 idle

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail <= '0;
        end else begin
            tail <= tail_deq + `LSU_IQ_IDX_W'(acc_0) + `LSU_IQ_IDX_W'(acc_1);
        end
    end

    // dispatch sources use the two extra scoreboard ports
    assign sb_rd_num_0[`LSU_IQ_DEPTH]   = din_0.uop.src0;
    assign sb_rd_num_0[`LSU_IQ_DEPTH+1] = din_1.uop.src0;
    assign sb_rd_num_1[`LSU_IQ_DEPTH]   = din_0.uop.src1;
    assign sb_rd_num_1[`LSU_IQ_DEPTH+1] = din_1.uop.src1;

    always_comb begin
        din_0_m = din_0;
        din_1_m = din_1;
        din_0_m.rdy.rdy0 = din_0.rdy.rdy0 | ~busy_0[`LSU_IQ_DEPTH];
        din_0_m.rdy.rdy1 = din_0.rdy.rdy1 | ~busy_1[`LSU_IQ_DEPTH];
        din_1_m.rdy.rdy0 = din_1.rdy.rdy0 | ~busy_0[`LSU_IQ_DEPTH+1];
        din_1_m.rdy.rdy1 = din_1.rdy.rdy1 | ~busy_1[`LSU_IQ_DEPTH+1];
    end

    // nothing above the top slot
    assign entries[`LSU_IQ_DEPTH] = '0;
    assign rdy_nxt[`LSU_IQ_DEPTH] = '0;

    for (genvar i = 0; i < `LSU_IQ_DEPTH; i++) begin : g_slot
        assign ctrl[i].enq_en   = (acc_0 && (pos_0 == `LSU_IQ_IDX_W'(i)))
                                || (acc_1 && (pos_1 == `LSU_IQ_IDX_W'(i)));
        assign ctrl[i].enq_sel  = acc_1 && (pos_1 == `LSU_IQ_IDX_W'(i));
        assign ctrl[i].shift_en = deq_en && (slot_idx_t'(i) >= deq_idx);

        iq_entry u_entry (
            .clk      (clk),
            .rst      (rst),
            .flush    (flush),
            .ctrl     (ctrl[i]),
            .din_0    (din_0_m),
            .din_1    (din_1_m),
            .up_entry (entries[i+1]),
            .up_rdy   (rdy_nxt[i+1]),
            .busy_0   (busy_0[i]),
            .busy_1   (busy_1[i]),
            .entry    (entries[i]),
            .rdy_next (rdy_nxt[i]),
            .src_0    (sb_rd_num_0[i]),
            .src_1    (sb_rd_num_1[i])
        );

        assign valid_vec[i] = (`LSU_IQ_IDX_W'(i) < tail);
        assign ready_vec[i] = entries[i].rdy.rdy0 & entries[i].rdy.rdy1;
        assign store_vec[i] = entries[i].is_store;
    end

    assign deq_entry = entries[deq_idx];

endmodule

// File: verilog/lsu_issue_select.sv
`include "lsu_iq_macros.svh"

module lsu_issue_select
    import lsu_iq_pkg::*;
(
    input  logic [`LSU_IQ_DEPTH-1:0] valid_vec,
    input  logic [`LSU_IQ_DEPTH-1:0] ready_vec,
    input  logic [`LSU_IQ_DEPTH-1:0] store_vec,
    input  logic                     lsu_busy,
    output slot_idx_t                sel_idx,
    output logic                     sel_valid
);

    logic [`LSU_IQ_DEPTH-1:0] order_mask; // slots not behind a waiting store
    logic [`LSU_IQ_DEPTH-1:0] cand;

    // slot 0 is oldest, so walk upward and cut everything past the first store
    always_comb begin
        logic store_seen;
        store_seen = 1'b0;
        for (int i = 0; i < `LSU_IQ_DEPTH; i++) begin
            order_mask[i] = ~store_seen;
            if (valid_vec[i] && store_vec[i]) begin
                store_seen = 1'b1;
            end
        end
    end

    assign cand = valid_vec & ready_vec & order_mask & {`LSU_IQ_DEPTH{~lsu_busy}};

    // lowest index wins
    always_comb begin
        sel_idx = '0;
        for (int i = `LSU_IQ_DEPTH - 1; i >= 0; i--) begin
            if (cand[i]) begin
                sel_idx = slot_idx_t'(i);
            end
        end
    end

    assign sel_valid = |cand;

endmodule

// File: verilog/lsu_issue_unit.sv
`include "lsu_iq_macros.svh"

module lsu_issue_unit
    import lsu_iq_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     enq_req_0,
    input  logic                     enq_req_1,
    input  iq_entry_t                din_0,
    input  iq_entry_t                din_1,
    input  logic                     lsu_busy,
    output logic                     ready,
    output logic                     issue_en,
    output lsu_uop_t                 issue_uop,
    output prf_num_t [`SB_PORTS-1:0] sb_rd_num_0,
    output prf_num_t [`SB_PORTS-1:0] sb_rd_num_1,
    input  logic [`SB_PORTS-1:0]     busy_0,
    input  logic [`SB_PORTS-1:0]     busy_1
);

    logic [`LSU_IQ_DEPTH-1:0] valid_vec;
    logic [`LSU_IQ_DEPTH-1:0] ready_vec;
    logic [`LSU_IQ_DEPTH-1:0] store_vec;
    slot_idx_t                sel_idx;
    logic                     sel_valid;
    iq_entry_t                deq_entry;

    iq_lsu u_iq_lsu (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .enq_req_0   (enq_req_0),
        .enq_req_1   (enq_req_1),
        .din_0       (din_0),
        .din_1       (din_1),
        .deq_en      (sel_valid), // selected entry leaves next edge
        .deq_idx     (sel_idx),
        .deq_entry   (deq_entry),
        .valid_vec   (valid_vec),
        .ready_vec   (ready_vec),
        .store_vec   (store_vec),
        .accepting   (ready),
        .sb_rd_num_0 (sb_rd_num_0),
        .sb_rd_num_1 (sb_rd_num_1),
        .busy_0      (busy_0),
        .busy_1      (busy_1)
    );

    lsu_issue_select u_select (
        .valid_vec (valid_vec),
        .ready_vec (ready_vec),
        .store_vec (store_vec),
        .lsu_busy  (lsu_busy),
        .sel_idx   (sel_idx),
        .sel_valid (sel_valid)
    );

    assign issue_en = sel_valid;

    always_comb begin
        issue_uop       = deq_entry.uop;
        issue_uop.valid = sel_valid;
    end

endmodule

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int HALF_PERIOD = 5 // 10 ns period
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

// File: bench/lsu_issue_asserts.sv
`include "lsu_iq_macros.svh"

module lsu_issue_asserts (
    input logic                     clk,
    input logic                     rst,
    input logic [`LSU_IQ_IDX_W-1:0] tail,
    input logic                     accepting,
    input logic [`LSU_IQ_DEPTH-1:0] valid_vec,
    input logic                     issue_en,
    input logic                     lsu_busy
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [`LSU_IQ_DEPTH-1:0] valid_inc;
    int                       fail_cnt = 0;

    // a packed run of ones plus one has no bit in common with the run
    assign valid_inc = valid_vec + `LSU_IQ_DEPTH'(1);

    tail_in_range: assert property (@(posedge clk) disable iff (rst)
        tail <= `LSU_IQ_IDX_W'(`LSU_IQ_DEPTH))
        else begin
            $error("tail count %0d exceeds queue depth", tail);
            fail_cnt++;
        end

    no_enq_when_full: assert property (@(posedge clk) disable iff (rst)
        !accepting |=> tail <= $past(tail))
        else begin
            $error("queue grew while not accepting");
            fail_cnt++;
        end

    busy_blocks_issue: assert property (@(posedge clk) disable iff (rst)
        lsu_busy |-> !issue_en)
        else begin
            $error("micro-op issued while execution unit busy");
            fail_cnt++;
        end

    valid_packed: assert property (@(posedge clk) disable iff (rst)
        (valid_vec & valid_inc) == '0)
        else begin
            $error("valid slots do not start at slot 0 without gaps");
            fail_cnt++;
        end

endmodule

// tail lives inside the queue instance
bind lsu_issue_unit lsu_issue_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .tail      (u_iq_lsu.tail),
    .accepting (ready),
    .valid_vec (valid_vec),
    .issue_en  (issue_en),
    .lsu_busy  (lsu_busy)
);

// File: bench/lsu_issue_tb.sv
`include "lsu_iq_macros.svh"

module lsu_issue_tb
    import lsu_iq_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CYCLES    = 3000;
    localparam int DRAIN_TIMEOUT = 60;
    localparam int RST_CYCLES    = 4;
    localparam int MAX_FILL      = `LSU_IQ_DEPTH - 2; // ready while count is at most this

    logic                     clk;
    logic                     rst;
    logic                     flush;
    logic                     enq_req_0;
    logic                     enq_req_1;
    iq_entry_t                din_0;
    iq_entry_t                din_1;
    logic                     lsu_busy;
    logic                     ready;
    logic                     issue_en;
    lsu_uop_t                 issue_uop;
    prf_num_t [`SB_PORTS-1:0] sb_rd_num_0;
    prf_num_t [`SB_PORTS-1:0] sb_rd_num_1;
    logic [`SB_PORTS-1:0]     busy_0;
    logic [`SB_PORTS-1:0]     busy_1;

    logic [(1 << `PRF_W)-1:0] busy_tbl; // scoreboard busy bit per register
    logic [31:0]              rand_state;
    iq_entry_t                mq [$];   // reference queue with the oldest at index 0
    logic                     clear_seen;
    logic                     last_issue;
    int                       cycle_cnt;
    int                       check_cnt;
    int                       mismatch_cnt;
    int                       timeout_cnt;
    int                       accepted_cnt;
    int                       issued_cnt;
    int                       discarded_cnt;

    tb_clock u_clock (.clk(clk));

    lsu_issue_unit dut0 (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .enq_req_0   (enq_req_0),
        .enq_req_1   (enq_req_1),
        .din_0       (din_0),
        .din_1       (din_1),
        .lsu_busy    (lsu_busy),
        .ready       (ready),
        .issue_en    (issue_en),
        .issue_uop   (issue_uop),
        .sb_rd_num_0 (sb_rd_num_0),
        .sb_rd_num_1 (sb_rd_num_1),
        .busy_0      (busy_0),
        .busy_1      (busy_1)
    );

    // scoreboard answers in the same cycle
    for (genvar g = 0; g < `SB_PORTS; g++) begin : g_sb
        assign busy_0[g] = busy_tbl[sb_rd_num_0[g]];
        assign busy_1[g] = busy_tbl[sb_rd_num_1[g]];
    end

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        return (lcg_next() >> 12) % n; // low bits of an lcg are weak
    endfunction

    function automatic prf_num_t rand_reg();
        return prf_num_t'(lcg_next() >> 20);
    endfunction

    function automatic iq_entry_t make_entry();
        iq_entry_t e;
        e.uop.valid  = 1'b1;
        e.uop.opcode = opc_t'(lcg_next() >> 16);
        e.uop.src0   = rand_reg();
        e.uop.src1   = rand_reg();
        e.uop.dst    = rand_reg();
        e.uop.imm    = imm_t'(lcg_next() >> 8);
        e.rdy.rdy0   = (rand_below(4) == 0);
        e.rdy.rdy1   = (rand_below(4) == 0);
        e.is_store   = (rand_below(10) < 3);
        return e;
    endfunction

    // dispatch flag or a clear busy bit
    function automatic iq_entry_t merge_dispatch(iq_entry_t e);
        iq_entry_t m;
        m = e;
        m.rdy.rdy0 = e.rdy.rdy0 | ~busy_tbl[e.uop.src0];
        m.rdy.rdy1 = e.rdy.rdy1 | ~busy_tbl[e.uop.src1];
        return m;
    endfunction

    task automatic compare_uop(input string name, input lsu_uop_t exp, input lsu_uop_t act);
        check_cnt++;
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch %s cycle %0d: expected %h, actual %h", name, cycle_cnt, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch %s cycle %0d: expected %b, actual %b", name, cycle_cnt, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        check_cnt++;
        if (act != exp) begin
            mismatch_cnt++;
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // runs at the falling edge, when dut outputs and inputs are settled
    task automatic check_and_advance();
        int        pick;
        logic      store_seen;
        lsu_uop_t  exp_uop;
        iq_entry_t e;
        int        n_before;
        pick = -1;
        store_seen = 1'b0;
        if (!lsu_busy) begin
            for (int p = 0; p < mq.size(); p++) begin
                if (pick < 0 && !store_seen && mq[p].rdy.rdy0 && mq[p].rdy.rdy1) begin
                    pick = p;
                end
                if (mq[p].is_store) begin
                    store_seen = 1'b1; // the oldest store fences everything younger
                end
            end
        end

        compare_bit("issue_en", (pick >= 0), issue_en);
        compare_bit("issue_uop_valid", (pick >= 0), issue_uop.valid);
        if (pick >= 0) begin
            exp_uop = mq[pick].uop;
            exp_uop.valid = 1'b1;
            compare_uop("issue_uop", exp_uop, issue_uop);
        end
        compare_bit("ready", (mq.size() <= MAX_FILL), ready);
        if (lsu_busy) begin
            compare_bit("busy_blocks_issue", 1'b0, issue_en);
        end
        if (clear_seen) begin
            compare_bit("cleared_issue_en", 1'b0, issue_en);
            compare_bit("cleared_ready", 1'b1, ready);
        end
        last_issue = issue_en;

        clear_seen = flush;
        if (flush) begin
            discarded_cnt += mq.size();
            mq.delete();
        end else begin
            if (issue_en) begin
                issued_cnt++;
            end
            n_before = mq.size();
            for (int p = 0; p < mq.size(); p++) begin
                e = mq[p];
                e.rdy.rdy0 = ~busy_tbl[e.uop.src0];
                e.rdy.rdy1 = ~busy_tbl[e.uop.src1];
                mq[p] = e;
            end
            if (pick >= 0) begin
                mq.delete(pick);
            end
            if (n_before <= MAX_FILL) begin
                if (enq_req_0) begin
                    mq.push_back(merge_dispatch(din_0));
                    accepted_cnt++;
                end
                if (enq_req_1) begin
                    mq.push_back(merge_dispatch(din_1)); // lane 1 is younger
                    accepted_cnt++;
                end
            end
        end
    endtask

    task automatic drive_inputs(input logic active);
        logic [(1 << `PRF_W)-1:0] nb;
        iq_entry_t                e0;
        iq_entry_t                e1;
        logic                     r0;
        logic                     r1;
        prf_num_t                 rr;
        nb = busy_tbl;
        e0 = make_entry();
        e1 = make_entry();
        r0 = 1'b0;
        r1 = 1'b0;
        if (active) begin
            if (mq.size() <= MAX_FILL) begin // model now matches the dut state
                r0 = (rand_below(100) < 55);
                r1 = (rand_below(100) < 40);
            end
            rr = rand_reg();
            nb[rr] = 1'b0;
            rr = rand_reg();
            nb[rr] = 1'b0;
            if (rand_below(6) == 0) begin
                rr = rand_reg();
                nb[rr] = 1'b1;
            end
            if (r0 && rand_below(2) == 0) begin
                nb[e0.uop.dst] = 1'b1;
            end
            if (r1 && rand_below(2) == 0) begin
                nb[e1.uop.dst] = 1'b1;
            end
            lsu_busy <= (rand_below(5) == 0);
            flush    <= (rand_below(80) == 0);
        end else begin
            nb = '0; // drain with every register available
            lsu_busy <= 1'b0;
            flush    <= 1'b0;
        end
        busy_tbl  <= nb;
        enq_req_0 <= r0;
        enq_req_1 <= r1;
        din_0     <= e0;
        din_1     <= e1;
    endtask

    task automatic run_cycle(input logic active);
        @(negedge clk);
        check_and_advance();
        @(posedge clk);
        drive_inputs(active);
        cycle_cnt++;
    endtask

    task automatic drain_queue();
        int waited;
        waited = 0;
        do begin
            run_cycle(1'b0);
            waited++;
        end while ((mq.size() != 0 || last_issue) && waited < DRAIN_TIMEOUT);
        if (mq.size() != 0 || last_issue) begin
            timeout_cnt++;
            $display("Timeout: queue did not drain within %0d cycles, %0d entries left",
                     DRAIN_TIMEOUT, mq.size());
        end
    endtask

    initial begin
        rand_state     = 32'hb459_0b9f;
        rst            = 1'b1;
        flush          = 1'b0;
        enq_req_0      = 1'b0;
        enq_req_1      = 1'b0;
        din_0          = '0;
        din_1          = '0;
        lsu_busy       = 1'b0;
        busy_tbl[31:0]  = lcg_next();
        busy_tbl[63:32] = lcg_next();
        clear_seen     = 1'b1; // reset leaves the queue empty
        last_issue     = 1'b0;
        cycle_cnt      = 0;
        check_cnt      = 0;
        mismatch_cnt   = 0;
        timeout_cnt    = 0;
        accepted_cnt   = 0;
        issued_cnt     = 0;
        discarded_cnt  = 0;

        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int c = 0; c < NUM_CYCLES; c++) begin
            run_cycle(1'b1);
        end
        drain_queue();
        compare_count("issued_total", accepted_cnt - discarded_cnt, issued_cnt);

        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures (%0d checks)",
                 mismatch_cnt, timeout_cnt, dut0.u_asserts.fail_cnt, check_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0 && dut0.u_asserts.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+common
common/lsu_iq_pkg.sv
issue_queue/iq_entry.sv
issue_queue/iq_lsu.sv
verilog/lsu_issue_select.sv
verilog/lsu_issue_unit.sv
bench/tb_clock.sv
bench/lsu_issue_asserts.sv
bench/lsu_issue_tb.sv

// File: Makefile
TOP = lsu_issue_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f src.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
